//--- folded_history.sv
// Fold is only correct if hist_i is the window after the shift that shift_i reports
`timescale 1ns/1ps

module folded_history #(
    parameter int IN_LEN  = 11,
    parameter int OUT_LEN = 11
) (
    input  logic               clk,
    input  logic               arst_n_i,

    input  logic               shift_i,
    input  logic [IN_LEN-1:0]  hist_i,
    output logic [OUT_LEN-1:0] fold_o
);

    // Bit position where the outgoing history bit lands
    localparam int OUT_POS = (IN_LEN - 1) % OUT_LEN;

    logic [OUT_LEN-1:0] fold_q;
    logic [OUT_LEN-1:0] fold_rot;
    logic [OUT_LEN-1:0] fold_next;

    ////////////////////////////////////////////////////////////
    // Incremental fold update
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Rotate left by one, also valid for a 1-bit fold
        fold_rot  = (fold_q << 1) | (fold_q >> (OUT_LEN - 1));
        fold_next = fold_rot;
        // Newest bit in
        fold_next[0] = fold_next[0] ^ hist_i[0];
        // Bit leaving the HIST_LEN window out
        fold_next[OUT_POS] = fold_next[OUT_POS] ^ hist_i[IN_LEN-1];
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fold_q <= '0;
        end else if (shift_i) begin
            fold_q <= fold_next;
        end
    end

    assign fold_o = fold_q;

endmodule

//--- global_history.sv
// Outcomes enter at bit 0; the window is one bit longer than HIST_LEN and is valid with the pulse
`timescale 1ns/1ps

module global_history #(
    parameter int HIST_LEN = 10
) (
    input  logic              clk,
    input  logic              arst_n_i,

    // Resolved branch outcome
    input  logic              hist_valid_i,
    input  logic              hist_taken_i,

    // History window and shift strobe
    output logic [HIST_LEN:0] hist_vec_o,
    output logic              hist_shift_o
);

    logic [HIST_LEN:0] hist_q;
    logic              shift_q;

    ////////////////////////////////////////////////////////////
    // History shift register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q  <= '0;
            shift_q <= 1'b0;
        end else begin
            shift_q <= hist_valid_i;
            if (hist_valid_i) begin
                // Oldest bit drops out of the top
                hist_q <= {hist_q[HIST_LEN-1:0], hist_taken_i};
            end
        end
    end

    assign hist_vec_o   = hist_q;
    assign hist_shift_o = shift_q;

    // Folds downstream count shifts, so a pulse must match exactly one outcome
    a_shift_needs_valid : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !hist_valid_i |=> !hist_shift_o
    );

endmodule

//--- pht_ram.sv
// DEPTH must be a power of two; writes are ignored and read data is undefined until ready_o rises
`timescale 1ns/1ps

module pht_ram #(
    parameter int DEPTH = 2048
) (
    input  logic                     clk,
    input  logic                     arst_n_i,

    // Read port, data one cycle after the address
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output tage_pkg::pht_entry_t     rd_data_o,

    // Write port
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  tage_pkg::pht_entry_t     wr_data_i,

    output logic                     ready_o
);

    import tage_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);

    pht_entry_t mem [DEPTH];
    pht_entry_t rd_data_q;

    clr_state_t    state_q;
    logic [AW-1:0] clr_cnt_q;

    logic          mem_we;
    logic [AW-1:0] mem_waddr;
    pht_entry_t    mem_wdata;

    ////////////////////////////////////////////////////////////
    // Clearing sweep
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= CLEARING;
            clr_cnt_q <= '0;
        end else if (state_q == CLEARING) begin
            clr_cnt_q <= clr_cnt_q + 1'b1;
            if (clr_cnt_q == LAST_ADDR) begin
                state_q <= RUNNING;
            end
        end
    end

    assign ready_o = (state_q == RUNNING);

    // Sweep owns the write port until it ends
    always_comb begin
        if (state_q == CLEARING) begin
            mem_we    = 1'b1;
            mem_waddr = clr_cnt_q;
            mem_wdata = '0;
        end else begin
            mem_we    = wr_en_i;
            mem_waddr = wr_addr_i;
            mem_wdata = wr_data_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage, read-first
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_data_q <= mem[rd_addr_i];
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    assign rd_data_o = rd_data_q;

    // Once the sweep is done the table stays usable until the next reset
    a_ready_sticky : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ready_o |=> ready_o
    );

endmodule

//--- src.f
tage_pkg.sv
global_history.sv
folded_history.sv
pht_ram.sv
tagged_predictor.sv
tage_top.sv
tb_clock_gen.sv
tage_tb.sv

//--- tage_pkg.sv
// Shared widths and types; struct widths are fixed here, hit_index and index are zero-extended
package tage_pkg;

    ////////////////////////////////////////////////////////////
    // Size constants
    ////////////////////////////////////////////////////////////

    // PC width
    parameter int ADDR_WIDTH = 32;

    // Direction counter width
    parameter int CTR_WIDTH = 3;

    // Useful field width
    parameter int USEFUL_WIDTH = 2;

    // Partial tag width
    parameter int TAG_WIDTH = 8;

    // Index fields are sized for the largest supported table (4096 entries)
    parameter int IDX_MAX_WIDTH = 12;

    ////////////////////////////////////////////////////////////
    // Table entry and query result
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [CTR_WIDTH-1:0]    ctr;
        logic [TAG_WIDTH-1:0]    tag;
        logic [USEFUL_WIDTH-1:0] useful;
    } pht_entry_t;

    typedef struct packed {
        logic                     taken;
        logic                     tag_hit;
        logic [CTR_WIDTH-1:0]     ctr;
        logic [USEFUL_WIDTH-1:0]  useful;
        logic [TAG_WIDTH-1:0]     query_tag;
        logic [TAG_WIDTH-1:0]     origin_tag;
        logic [IDX_MAX_WIDTH-1:0] hit_index;
    } pred_meta_t;

    ////////////////////////////////////////////////////////////
    // Update request
    ////////////////////////////////////////////////////////////

    // Flags are independent, realloc wins over the counter and useful steps
    typedef struct packed {
        logic                     valid;
        logic                     upd_ctr;
        logic                     inc_ctr;
        logic                     upd_useful;
        logic                     inc_useful;
        logic                     realloc;
        logic [CTR_WIDTH-1:0]     old_ctr;
        logic [USEFUL_WIDTH-1:0]  old_useful;
        logic [TAG_WIDTH-1:0]     new_tag;
        logic [IDX_MAX_WIDTH-1:0] index;
    } pht_update_t;

    // Table clearing sweep after reset
    typedef enum logic {
        CLEARING,
        RUNNING
    } clr_state_t;

endpackage

//--- tage_tb.sv
// Fixed to HIST_LEN 6 and PHT_DEPTH 64; the model starts from zero history and a cleared table
`timescale 1ns/1ps

module tage_tb;

    import tage_pkg::*;

    localparam int HL      = 6;
    localparam int DEPTH   = 64;
    localparam int IW      = $clog2(DEPTH);
    localparam int PERIOD  = 100;
    localparam int RST_CYC = 5;
    localparam int CTR_MAX = (1 << CTR_WIDTH) - 1;
    localparam int USE_MAX = (1 << USEFUL_WIDTH) - 1;
    localparam logic [31:0] PC_A = 32'h0000_1234;
    // Tag bits of this PC are zero, so it hits a cleared entry
    localparam logic [31:0] PC_Z = 32'h0000_0400;

    // Update kinds
    localparam logic [2:0] OP_NONE    = 3'd0;
    localparam logic [2:0] OP_REALLOC = 3'd1;
    localparam logic [2:0] OP_INC     = 3'd2;
    localparam logic [2:0] OP_DEC     = 3'd3;
    localparam logic [2:0] OP_UINC    = 3'd4;
    localparam logic [2:0] OP_UDEC    = 3'd5;
    localparam logic [2:0] OP_KEEP    = 3'd6;
    // Expected flag not checked
    localparam logic [1:0] X = 2'd2;

    typedef struct packed {
        logic        hv;
        logic        ht;
        logic        rnd;
        logic [31:0] pc;
        logic [2:0]  op;
        logic [3:0]  reps;
        logic [1:0]  exp_hit;
        logic [1:0]  exp_taken;
    } row_t;

    logic                  clk;
    logic                  arst_n;
    logic                  hist_valid;
    logic                  hist_taken;
    logic [ADDR_WIDTH-1:0] query_pc;
    pht_update_t           upd;
    pred_meta_t            meta;
    logic                  ready;

    ////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////

    logic [HL:0] hist_m;
    logic        shift_m;
    logic [7:0]  fidx_m, f1_m, f2_m;
    pht_entry_t  table_m [DEPTH];
    int          edges_m;
    pred_meta_t  exp_meta;
    logic        exp_valid;
    logic [1:0]  pend_hit, pend_taken;
    logic        cur_hv, cur_ht;
    logic [31:0] cur_pc;
    pht_update_t cur_upd;

    row_t        rows [$];
    int          applied = 0;
    logic        table_done = 1'b0;
    logic [31:0] lfsr_q = 32'hdc0e_41a9;

    tb_clock_gen #(.PERIOD_NS(PERIOD), .RST_CYCLES(RST_CYC)) u_clock_gen (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    tage_top #(.HIST_LEN(HL), .PHT_DEPTH(DEPTH)) dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .hist_valid_i(hist_valid),
        .hist_taken_i(hist_taken),
        .pc_i        (query_pc),
        .meta_o      (meta),
        .upd_i       (upd),
        .ready_o     (ready)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic take_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int k = 0; k < 32; k++) begin
            w[k] = take_bit();
        end
        return w;
    endfunction

    // Rotate within w bits, newest bit in at 0, oldest bit out at HL mod w
    function automatic logic [7:0] fold_step(input logic [7:0] f, input int w, input logic [HL:0] h);
        logic [7:0] r;
        r = '0;
        for (int k = 0; k < w; k++) begin
            r[(k + 1) % w] = f[k];
        end
        r[0]      = r[0] ^ h[0];
        r[HL % w] = r[HL % w] ^ h[HL];
        return r;
    endfunction

    function automatic int sat_step(input int v, input int max_v, input logic inc);
        if (inc) begin
            return (v == max_v) ? v : v + 1;
        end
        return (v == 0) ? 0 : v - 1;
    endfunction

    function automatic logic [IW-1:0] idx_of(input logic [31:0] pc);
        return pc[IW-1:0] ^ pc[2*IW-1:IW] ^ fidx_m[IW-1:0];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] tag_of(input logic [31:0] pc);
        return pc[TAG_WIDTH+1:2] ^ f1_m ^ {f2_m[TAG_WIDTH-2:0], 1'b0};
    endfunction

    task automatic add_row(input logic hv, input logic ht, input logic rnd, input logic [31:0] pc,
                           input logic [2:0] op, input logic [3:0] reps,
                           input logic [1:0] hit, input logic [1:0] tkn);
        row_t r;
        r = '{hv: hv, ht: ht, rnd: rnd, pc: pc, op: op, reps: reps, exp_hit: hit, exp_taken: tkn};
        rows.push_back(r);
        applied += reps;
    endtask

    task automatic build_table();
        //      hv ht rnd pc    op          n  hit taken
        // Cleared table
        add_row(0, 0, 0, PC_Z, OP_NONE,    1, 1, 0);
        add_row(0, 0, 0, PC_A, OP_NONE,    1, 0, 0);
        // Allocate, counter up to 7 and down to 0
        add_row(0, 0, 0, PC_A, OP_REALLOC, 1, 0, 0);
        add_row(0, 0, 0, PC_A, OP_INC,     5, 1, 1);
        add_row(0, 0, 0, PC_A, OP_DEC,     4, 1, 1);
        add_row(0, 0, 0, PC_A, OP_DEC,     4, 1, 0);
        add_row(0, 0, 0, PC_A, OP_INC,     1, 1, 0);
        // Useful up to 3, back to 0, then clear flags
        add_row(0, 0, 0, PC_A, OP_UINC,    4, 1, 0);
        add_row(0, 0, 0, PC_A, OP_UDEC,    4, 1, 0);
        add_row(0, 0, 0, PC_A, OP_KEEP,    1, 1, 0);
        // A taken outcome moves PC_A to a fresh entry two cycles later
        add_row(1, 1, 0, PC_A, OP_NONE,    1, 1, 0);
        add_row(0, 0, 0, PC_A, OP_NONE,    1, 1, 0);
        add_row(0, 0, 0, PC_A, OP_NONE,    1, 0, 0);
        add_row(0, 0, 0, PC_A, OP_REALLOC, 1, 0, 0);
        add_row(0, 0, 0, PC_A, OP_NONE,    1, 1, 1);
        // Random history and PCs
        add_row(1, 0, 1, '0,   OP_REALLOC, 6, X, X);
        add_row(1, 0, 1, '0,   OP_NONE,    6, X, X);
        add_row(0, 0, 0, PC_A, OP_NONE,    1, X, X);
        add_row(0, 0, 0, PC_A, OP_REALLOC, 1, X, X);
        add_row(0, 0, 0, PC_A, OP_NONE,    1, 1, 1);
        add_row(0, 0, 0, '0,   OP_NONE,    1, X, X);
    endtask

    ////////////////////////////////////////////////////////////
    // Model step and checks
    ////////////////////////////////////////////////////////////

    // Expected meta for the current query, then everything the next edge does
    task automatic model_edge();
        logic [IW-1:0] idx;
        pht_entry_t    ent;
        pht_entry_t    nxt;
        logic          ready_now;
        ready_now = (edges_m >= DEPTH);
        idx = idx_of(cur_pc);
        ent = table_m[idx];
        exp_valid = ready_now;
        exp_meta  = '{taken: ent.ctr[CTR_WIDTH-1], tag_hit: (tag_of(cur_pc) == ent.tag),
                      ctr: ent.ctr, useful: ent.useful, query_tag: tag_of(cur_pc),
                      origin_tag: ent.tag, hit_index: IDX_MAX_WIDTH'(idx)};
        if (cur_upd.valid && ready_now) begin
            nxt.tag    = cur_upd.new_tag;
            nxt.ctr    = cur_upd.old_ctr;
            nxt.useful = cur_upd.old_useful;
            if (cur_upd.upd_ctr) begin
                nxt.ctr = CTR_WIDTH'(sat_step(cur_upd.old_ctr, CTR_MAX, cur_upd.inc_ctr));
            end
            if (cur_upd.upd_useful) begin
                nxt.useful = USEFUL_WIDTH'(sat_step(cur_upd.old_useful, USE_MAX,
                                                    cur_upd.inc_useful));
            end
            if (cur_upd.realloc) begin
                nxt.ctr    = CTR_WIDTH'(1 << (CTR_WIDTH - 1));
                nxt.useful = '0;
            end
            table_m[cur_upd.index[IW-1:0]] = nxt;
        end
        // Folds see the window shifted one edge earlier
        if (shift_m) begin
            fidx_m = fold_step(fidx_m, IW, hist_m);
            f1_m   = fold_step(f1_m, TAG_WIDTH, hist_m);
            f2_m   = fold_step(f2_m, TAG_WIDTH - 1, hist_m);
        end
        shift_m = cur_hv;
        if (cur_hv) begin
            hist_m = {hist_m[HL-1:0], cur_ht};
        end
        edges_m++;
    endtask

    task automatic check_outputs();
        assert (ready === (edges_m >= DEPTH)) else
            value_error($sformatf("ready_o is %b after %0d edges", ready, edges_m));
        if (exp_valid) begin
            assert (meta === exp_meta) else
                value_error($sformatf("meta_o is %h, expected %h", meta, exp_meta));
            assert (pend_hit == X || meta.tag_hit == pend_hit[0]) else
                value_error($sformatf("tag_hit is %b, table expects %0d", meta.tag_hit, pend_hit));
            assert (pend_taken == X || meta.taken == pend_taken[0]) else
                value_error($sformatf("taken is %b, table expects %0d", meta.taken, pend_taken));
        end
    endtask

    task automatic do_cycle(input row_t r);
        logic [31:0]   pc;
        logic          ht;
        logic [IW-1:0] idx;
        pht_update_t   u;
        @(posedge clk);
        pc = r.rnd ? rand_word() : r.pc;
        ht = r.rnd ? take_bit() : r.ht;
        idx = idx_of(pc);
        u = '0;
        if (r.op != OP_NONE) begin
            u.valid      = 1'b1;
            u.index      = IDX_MAX_WIDTH'(idx);
            u.old_ctr    = table_m[idx].ctr;
            u.old_useful = table_m[idx].useful;
            u.new_tag    = (r.op == OP_REALLOC) ? tag_of(pc) : table_m[idx].tag;
        end
        u.realloc    = (r.op == OP_REALLOC);
        u.upd_ctr    = (r.op == OP_INC) || (r.op == OP_DEC);
        u.inc_ctr    = (r.op == OP_INC);
        u.upd_useful = (r.op == OP_UINC) || (r.op == OP_UDEC);
        u.inc_useful = (r.op == OP_UINC);
        hist_valid <= r.hv;
        hist_taken <= ht;
        query_pc   <= pc;
        upd        <= u;
        {cur_hv, cur_ht, cur_pc, cur_upd} = {r.hv, ht, pc, u};
        @(negedge clk);
        check_outputs();
        {pend_hit, pend_taken} = {r.exp_hit, r.exp_taken};
        model_edge();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        row_t sweep_row;
        {hist_valid, hist_taken, query_pc, upd} = '0;
        {hist_m, shift_m, fidx_m, f1_m, f2_m, edges_m} = '0;
        {cur_hv, cur_ht, cur_pc, cur_upd, exp_valid} = '0;
        {pend_hit, pend_taken} = {X, X};
        for (int k = 0; k < DEPTH; k++) begin
            table_m[k] = '0;
        end
        build_table();
        table_done = 1'b1;
        // Allocations during the sweep must be dropped
        sweep_row = '{hv: 0, ht: 0, rnd: 0, pc: PC_A, op: OP_REALLOC, reps: 1,
                      exp_hit: X, exp_taken: X};
        @(posedge arst_n);
        model_edge();
        // Every update driven here is sampled before ready_o rises
        while (edges_m < DEPTH) begin
            do_cycle(sweep_row);
        end
        foreach (rows[i]) begin
            repeat (rows[i].reps) do_cycle(rows[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (table_done);
        limit = RST_CYC + DEPTH + 2 * applied + 20;
        #(limit * PERIOD);
        abort_run("Timeout: the run did not finish within its cycle budget");
    end

endmodule

//--- tage_top.sv
// Single tagged table, no base predictor; queries are meaningless while ready_o is low
`timescale 1ns/1ps

module tage_top #(
    parameter int HIST_LEN  = 10,
    parameter int PHT_DEPTH = 2048
) (
    input  logic                            clk,
    input  logic                            arst_n_i,

    // Resolved branch outcomes
    input  logic                            hist_valid_i,
    input  logic                            hist_taken_i,

    // Query
    input  logic [tage_pkg::ADDR_WIDTH-1:0] pc_i,
    output tage_pkg::pred_meta_t            meta_o,

    // Update
    input  tage_pkg::pht_update_t           upd_i,

    output logic                            ready_o
);

    // History window and its strobe
    logic [HIST_LEN:0] hist_vec;
    logic              hist_shift;

    ////////////////////////////////////////////////////////////
    // History producer
    ////////////////////////////////////////////////////////////

    global_history #(
        .HIST_LEN(HIST_LEN)
    ) u_global_history (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .hist_valid_i(hist_valid_i),
        .hist_taken_i(hist_taken_i),
        .hist_vec_o  (hist_vec),
        .hist_shift_o(hist_shift)
    );

    ////////////////////////////////////////////////////////////
    // Tagged table
    ////////////////////////////////////////////////////////////

    tagged_predictor #(
        .HIST_LEN (HIST_LEN),
        .PHT_DEPTH(PHT_DEPTH)
    ) u_tagged_predictor (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .hist_shift_i(hist_shift),
        .hist_vec_i  (hist_vec),
        .pc_i        (pc_i),
        .meta_o      (meta_o),
        .upd_i       (upd_i),
        .ready_o     (ready_o)
    );

endmodule

//--- tagged_predictor.sv
// Update decisions come from outside; PC must be at least 2*log2(PHT_DEPTH) bits wide
`timescale 1ns/1ps

module tagged_predictor #(
    parameter int HIST_LEN  = 10,
    parameter int PHT_DEPTH = 2048
) (
    input  logic                            clk,
    input  logic                            arst_n_i,

    // History from the global history register
    input  logic                            hist_shift_i,
    input  logic [HIST_LEN:0]               hist_vec_i,

    // Query
    input  logic [tage_pkg::ADDR_WIDTH-1:0] pc_i,
    output tage_pkg::pred_meta_t            meta_o,

    // Update
    input  tage_pkg::pht_update_t           upd_i,

    output logic                            ready_o
);

    import tage_pkg::*;

    localparam int IDX_W = $clog2(PHT_DEPTH);

    // Folded histories
    logic [IDX_W-1:0]     idx_fold;
    logic [TAG_WIDTH-1:0] tag_fold1;
    logic [TAG_WIDTH-2:0] tag_fold2;

    // Query path
    logic [IDX_W-1:0]     query_idx;
    logic [IDX_W-1:0]     query_idx_q;
    logic [TAG_WIDTH-1:0] query_tag;
    logic [TAG_WIDTH-1:0] query_tag_q;
    pht_entry_t           rd_entry;

    // Update path
    pht_entry_t           upd_entry;

    ////////////////////////////////////////////////////////////
    // History folds
    ////////////////////////////////////////////////////////////

    folded_history #(
        .IN_LEN (HIST_LEN + 1),
        .OUT_LEN(IDX_W)
    ) u_idx_fold (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .shift_i (hist_shift_i),
        .hist_i  (hist_vec_i),
        .fold_o  (idx_fold)
    );

    folded_history #(
        .IN_LEN (HIST_LEN + 1),
        .OUT_LEN(TAG_WIDTH)
    ) u_tag_fold1 (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .shift_i (hist_shift_i),
        .hist_i  (hist_vec_i),
        .fold_o  (tag_fold1)
    );

    // One bit shorter so the two tag folds differ
    folded_history #(
        .IN_LEN (HIST_LEN + 1),
        .OUT_LEN(TAG_WIDTH - 1)
    ) u_tag_fold2 (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .shift_i (hist_shift_i),
        .hist_i  (hist_vec_i),
        .fold_o  (tag_fold2)
    );

    ////////////////////////////////////////////////////////////
    // Query
    ////////////////////////////////////////////////////////////

    assign query_idx = pc_i[0 +: IDX_W] ^ pc_i[IDX_W +: IDX_W] ^ idx_fold;
    assign query_tag = pc_i[2 +: TAG_WIDTH] ^ tag_fold1 ^ {tag_fold2, 1'b0};

    // Align with the registered RAM read
    always_ff @(posedge clk) begin
        query_idx_q <= query_idx;
        query_tag_q <= query_tag;
    end

    always_comb begin
        meta_o.taken      = rd_entry.ctr[CTR_WIDTH-1];
        meta_o.tag_hit    = (query_tag_q == rd_entry.tag);
        meta_o.ctr        = rd_entry.ctr;
        meta_o.useful     = rd_entry.useful;
        meta_o.query_tag  = query_tag_q;
        meta_o.origin_tag = rd_entry.tag;
        meta_o.hit_index  = IDX_MAX_WIDTH'(query_idx_q);
    end

    ////////////////////////////////////////////////////////////
    // Update entry
    ////////////////////////////////////////////////////////////

    always_comb begin
        upd_entry.tag    = upd_i.new_tag;
        upd_entry.ctr    = upd_i.old_ctr;
        upd_entry.useful = upd_i.old_useful;

        // Saturating counter step
        if (upd_i.upd_ctr) begin
            if (upd_i.inc_ctr) begin
                if (upd_i.old_ctr != '1) begin
                    upd_entry.ctr = upd_i.old_ctr + 1'b1;
                end
            end else if (upd_i.old_ctr != '0) begin
                upd_entry.ctr = upd_i.old_ctr - 1'b1;
            end
        end

        // Saturating useful step
        if (upd_i.upd_useful) begin
            if (upd_i.inc_useful) begin
                if (upd_i.old_useful != '1) begin
                    upd_entry.useful = upd_i.old_useful + 1'b1;
                end
            end else if (upd_i.old_useful != '0) begin
                upd_entry.useful = upd_i.old_useful - 1'b1;
            end
        end

        // New owner starts weakly taken, not yet useful
        if (upd_i.realloc) begin
            upd_entry.ctr    = {1'b1, {(CTR_WIDTH - 1){1'b0}}};
            upd_entry.useful = '0;
        end
    end

    // Table, drops writes by itself during the sweep
    pht_ram #(
        .DEPTH(PHT_DEPTH)
    ) u_pht_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rd_addr_i(query_idx),
        .rd_data_o(rd_entry),
        .wr_en_i  (upd_i.valid),
        .wr_addr_i(upd_i.index[IDX_W-1:0]),
        .wr_data_i(upd_entry),
        .ready_o  (ready_o)
    );

    // Realloc without valid would silently lose an allocation decision
    a_realloc_valid : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        upd_i.realloc |-> upd_i.valid
    );

endmodule

//--- tb_clock_gen.sv
// Free-running clock from time zero; reset is released on a falling edge after RST_CYCLES edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule
